/* src/cpu_isa_pkg.sv */
package cpu_isa_pkg;

    localparam int word_w    = 16;
    localparam int reg_idx_w = 3;

    typedef logic [word_w-1:0]    word_t;     // data word, pc or instruction
    typedef logic [reg_idx_w-1:0] reg_idx_t;

    // field positions in the instruction word
    localparam int op_lo = 11;     // opcode in 15:11
    localparam int ra_lo = 8;      // first register, 10:8
    localparam int rb_lo = 5;      // second register, 7:5
    localparam int rw_lo = 2;      // r-type destination, 4:2

    // immediate widths, each starting at bit 0
    localparam int imm_i_w = 5;    // addi
    localparam int imm_b_w = 8;    // beqz, bnez
    localparam int imm_j_w = 11;   // j

    // every code not listed here decodes as a nop
    typedef enum logic [4:0] {
        op_add  = 5'b00001,
        op_sub  = 5'b00010,
        op_and  = 5'b00011,
        op_xor  = 5'b00100,
        op_slt  = 5'b00101,
        op_addi = 5'b01000,
        op_beqz = 5'b01100,
        op_bnez = 5'b01101,
        op_j    = 5'b10000,
        op_halt = 5'b11111
    } opcode_t;

endpackage

/* src/cpu_ctrl_pkg.sv */
package cpu_ctrl_pkg;

    // alu operation carried from decode into execute
    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_xor = 3'd3,
        alu_slt = 3'd4     // signed compare, result is 1 or 0
    } alu_op_t;

    // branch condition, tested on the first operand in execute
    typedef enum logic [1:0] {
        br_none   = 2'd0,
        br_eqz    = 2'd1,
        br_nez    = 2'd2,
        br_always = 2'd3   // j
    } br_cnd_t;

endpackage

/* src/instr_decoder.sv */
module instr_decoder (
    input  cpu_isa_pkg::word_t    instr,
    output cpu_isa_pkg::reg_idx_t rd_reg_1,
    output cpu_isa_pkg::reg_idx_t rd_reg_2,
    output cpu_isa_pkg::reg_idx_t wr_reg,
    output cpu_isa_pkg::word_t    sext_imm,
    output cpu_ctrl_pkg::alu_op_t alu_op,
    output logic                  use_imm,
    output logic                  wr_en,
    output logic                  halt_instr,
    output cpu_ctrl_pkg::br_cnd_t br_cnd
);

    cpu_isa_pkg::opcode_t  opcode;
    cpu_isa_pkg::reg_idx_t field_a;
    cpu_isa_pkg::reg_idx_t field_b;
    cpu_isa_pkg::reg_idx_t field_w;
    cpu_isa_pkg::word_t    imm_i;
    cpu_isa_pkg::word_t    imm_b;
    cpu_isa_pkg::word_t    imm_j;

    assign opcode  = cpu_isa_pkg::opcode_t'(instr[cpu_isa_pkg::op_lo +: 5]);
    assign field_a = instr[cpu_isa_pkg::ra_lo +: cpu_isa_pkg::reg_idx_w];
    assign field_b = instr[cpu_isa_pkg::rb_lo +: cpu_isa_pkg::reg_idx_w];
    assign field_w = instr[cpu_isa_pkg::rw_lo +: cpu_isa_pkg::reg_idx_w];

    // sign extension through signed casts
    assign imm_i = cpu_isa_pkg::word_t'($signed(instr[cpu_isa_pkg::imm_i_w-1:0]));
    assign imm_b = cpu_isa_pkg::word_t'($signed(instr[cpu_isa_pkg::imm_b_w-1:0]));
    assign imm_j = cpu_isa_pkg::word_t'($signed(instr[cpu_isa_pkg::imm_j_w-1:0]));

    assign rd_reg_2 = field_b;

    always_comb begin
        rd_reg_1   = field_a;
        wr_reg     = field_w;
        sext_imm   = '0;
        alu_op     = cpu_ctrl_pkg::alu_add;
        use_imm    = 1'b0;
        wr_en      = 1'b0;
        halt_instr = 1'b0;
        br_cnd     = cpu_ctrl_pkg::br_none;
        case (opcode)
            cpu_isa_pkg::op_add: wr_en = 1'b1;
            cpu_isa_pkg::op_sub: begin
                wr_en  = 1'b1;
                alu_op = cpu_ctrl_pkg::alu_sub;
            end
            cpu_isa_pkg::op_and: begin
                wr_en  = 1'b1;
                alu_op = cpu_ctrl_pkg::alu_and;
            end
            cpu_isa_pkg::op_xor: begin
                wr_en  = 1'b1;
                alu_op = cpu_ctrl_pkg::alu_xor;
            end
            cpu_isa_pkg::op_slt: begin
                wr_en  = 1'b1;
                alu_op = cpu_ctrl_pkg::alu_slt;
            end
            cpu_isa_pkg::op_addi: begin
                wr_en    = 1'b1;
                use_imm  = 1'b1;
                rd_reg_1 = field_b;   // source is the second field, so it lands on operand a
                wr_reg   = field_a;
                sext_imm = imm_i;
            end
            cpu_isa_pkg::op_beqz: begin
                br_cnd   = cpu_ctrl_pkg::br_eqz;
                sext_imm = imm_b;
            end
            cpu_isa_pkg::op_bnez: begin
                br_cnd   = cpu_ctrl_pkg::br_nez;
                sext_imm = imm_b;
            end
            cpu_isa_pkg::op_j: begin
                br_cnd   = cpu_ctrl_pkg::br_always;
                sext_imm = imm_j;
            end
            cpu_isa_pkg::op_halt: halt_instr = 1'b1;
            default: ;   // nop, all enables stay low
        endcase
    end

endmodule

/* src/reg_file.sv */
module reg_file (
    input  logic                  clk,
    input  logic                  reset,
    input  cpu_isa_pkg::reg_idx_t rd_reg_1,
    input  cpu_isa_pkg::reg_idx_t rd_reg_2,
    input  logic                  wr_en,
    input  cpu_isa_pkg::reg_idx_t wr_reg,
    input  cpu_isa_pkg::word_t    wr_data,
    output cpu_isa_pkg::word_t    rd_data_1,
    output cpu_isa_pkg::word_t    rd_data_2
);

    localparam int num_regs = 2 ** cpu_isa_pkg::reg_idx_w;

    cpu_isa_pkg::word_t regs [num_regs];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_reg] <= wr_data;
        end
    end

    // write-through, a read in the write cycle already sees the new value
    assign rd_data_1 = (wr_en && (wr_reg == rd_reg_1)) ? wr_data : regs[rd_reg_1];
    assign rd_data_2 = (wr_en && (wr_reg == rd_reg_2)) ? wr_data : regs[rd_reg_2];

endmodule

/* src/id_ex.sv */
module id_ex (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  valid,         // low inserts a bubble
    input  logic                  take_new_pc,   // squash the instruction in decode
    input  cpu_isa_pkg::word_t    in_pc_inc,
    input  cpu_isa_pkg::word_t    in_rd_data_1,
    input  cpu_isa_pkg::word_t    in_rd_data_2,
    input  cpu_isa_pkg::reg_idx_t in_rd_reg_1,
    input  cpu_isa_pkg::reg_idx_t in_rd_reg_2,
    input  cpu_isa_pkg::reg_idx_t in_wr_reg,
    input  cpu_isa_pkg::word_t    in_sext_imm,
    input  cpu_ctrl_pkg::alu_op_t in_alu_op,
    input  logic                  in_use_imm,
    input  logic                  in_wr_en,
    input  cpu_ctrl_pkg::br_cnd_t in_br_cnd,
    input  logic                  in_halt,
    output cpu_isa_pkg::word_t    out_pc_inc,
    output cpu_isa_pkg::word_t    out_rd_data_1,
    output cpu_isa_pkg::word_t    out_rd_data_2,
    output cpu_isa_pkg::reg_idx_t out_rd_reg_1,
    output cpu_isa_pkg::reg_idx_t out_rd_reg_2,
    output cpu_isa_pkg::reg_idx_t out_wr_reg,
    output cpu_isa_pkg::word_t    out_sext_imm,
    output cpu_ctrl_pkg::alu_op_t out_alu_op,
    output logic                  out_use_imm,
    output logic                  out_wr_en,
    output cpu_ctrl_pkg::br_cnd_t out_br_cnd,
    output logic                  out_halt
);

    logic make_nop;

    assign make_nop = ~valid | take_new_pc;

    always_ff @(posedge clk) begin
        out_pc_inc    <= in_pc_inc;
        out_rd_data_1 <= in_rd_data_1;
        out_rd_data_2 <= in_rd_data_2;
        out_rd_reg_1  <= in_rd_reg_1;
        out_rd_reg_2  <= in_rd_reg_2;
        out_wr_reg    <= in_wr_reg;
        out_sext_imm  <= in_sext_imm;
    end

    // a nop keeps its fields but loses every side effect
    always_ff @(posedge clk) begin
        if (reset) begin
            out_alu_op  <= cpu_ctrl_pkg::alu_add;
            out_use_imm <= 1'b0;
            out_wr_en   <= 1'b0;
            out_br_cnd  <= cpu_ctrl_pkg::br_none;
            out_halt    <= 1'b0;
        end else begin
            out_alu_op  <= in_alu_op;
            out_use_imm <= in_use_imm;
            out_wr_en   <= in_wr_en & ~make_nop;
            out_br_cnd  <= make_nop ? cpu_ctrl_pkg::br_none : in_br_cnd;
            out_halt    <= in_halt & ~make_nop;   // squashed halt never ends the run
        end
    end

endmodule

/* src/alu_exec.sv */
module alu_exec (
    input  logic                  clk,
    input  logic                  reset,
    input  cpu_isa_pkg::word_t    pc_inc,
    input  cpu_isa_pkg::word_t    rd_data_1,
    input  cpu_isa_pkg::word_t    rd_data_2,
    input  cpu_isa_pkg::reg_idx_t rd_reg_1,
    input  cpu_isa_pkg::reg_idx_t rd_reg_2,
    input  cpu_isa_pkg::reg_idx_t wr_reg,
    input  cpu_isa_pkg::word_t    sext_imm,
    input  cpu_ctrl_pkg::alu_op_t alu_op,
    input  logic                  use_imm,
    input  logic                  wr_en,
    input  cpu_ctrl_pkg::br_cnd_t br_cnd,
    input  logic                  halt_instr,
    output logic                  redirect,
    output cpu_isa_pkg::word_t    redirect_pc,
    output logic                  wb_en,
    output cpu_isa_pkg::reg_idx_t wb_reg,
    output cpu_isa_pkg::word_t    wb_data,
    output logic                  halt
);

    logic               fwd_1;
    logic               fwd_2;
    cpu_isa_pkg::word_t op_a;
    cpu_isa_pkg::word_t op_b_reg;
    cpu_isa_pkg::word_t op_b;
    cpu_isa_pkg::word_t result;

    // forward from the writeback stage, one instruction back
    assign fwd_1    = wb_en && (wb_reg == rd_reg_1);
    assign fwd_2    = wb_en && (wb_reg == rd_reg_2);
    assign op_a     = fwd_1 ? wb_data : rd_data_1;
    assign op_b_reg = fwd_2 ? wb_data : rd_data_2;
    assign op_b     = use_imm ? sext_imm : op_b_reg;

    always_comb begin
        case (alu_op)
            cpu_ctrl_pkg::alu_sub: result = op_a - op_b;
            cpu_ctrl_pkg::alu_and: result = op_a & op_b;
            cpu_ctrl_pkg::alu_xor: result = op_a ^ op_b;
            cpu_ctrl_pkg::alu_slt: result = cpu_isa_pkg::word_t'($signed(op_a) < $signed(op_b));
            default:               result = op_a + op_b;
        endcase
    end

    // branch resolves on the forwarded first operand
    always_comb begin
        case (br_cnd)
            cpu_ctrl_pkg::br_eqz:    redirect = (op_a == '0);
            cpu_ctrl_pkg::br_nez:    redirect = (op_a != '0);
            cpu_ctrl_pkg::br_always: redirect = 1'b1;
            default:                 redirect = 1'b0;
        endcase
    end

    assign redirect_pc = pc_inc + sext_imm;

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_en <= 1'b0;
            halt  <= 1'b0;
        end else begin
            wb_en <= wr_en;
            halt  <= halt_instr;
        end
    end

    always_ff @(posedge clk) begin
        wb_reg  <= wr_reg;
        wb_data <= result;
    end

endmodule

/* src/pipe_core.sv */
module pipe_core (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  instr_valid,
    input  cpu_isa_pkg::word_t    pc,
    input  cpu_isa_pkg::word_t    instr,
    output logic                  redirect,
    output cpu_isa_pkg::word_t    redirect_pc,
    output logic                  wb_en,
    output cpu_isa_pkg::reg_idx_t wb_reg,
    output cpu_isa_pkg::word_t    wb_data,
    output logic                  halt
);

    cpu_isa_pkg::word_t    pc_inc;
    // decode stage
    cpu_isa_pkg::reg_idx_t dec_rd_reg_1;
    cpu_isa_pkg::reg_idx_t dec_rd_reg_2;
    cpu_isa_pkg::reg_idx_t dec_wr_reg;
    cpu_isa_pkg::word_t    dec_sext_imm;
    cpu_ctrl_pkg::alu_op_t dec_alu_op;
    logic                  dec_use_imm;
    logic                  dec_wr_en;
    logic                  dec_halt;
    cpu_ctrl_pkg::br_cnd_t dec_br_cnd;
    cpu_isa_pkg::word_t    rf_data_1;
    cpu_isa_pkg::word_t    rf_data_2;
    // execute stage
    cpu_isa_pkg::word_t    ex_pc_inc;
    cpu_isa_pkg::word_t    ex_rd_data_1;
    cpu_isa_pkg::word_t    ex_rd_data_2;
    cpu_isa_pkg::reg_idx_t ex_rd_reg_1;
    cpu_isa_pkg::reg_idx_t ex_rd_reg_2;
    cpu_isa_pkg::reg_idx_t ex_wr_reg;
    cpu_isa_pkg::word_t    ex_sext_imm;
    cpu_ctrl_pkg::alu_op_t ex_alu_op;
    logic                  ex_use_imm;
    logic                  ex_wr_en;
    cpu_ctrl_pkg::br_cnd_t ex_br_cnd;
    logic                  ex_halt;

    assign pc_inc = pc + cpu_isa_pkg::word_t'(2);

    instr_decoder instr_decoder_inst (
        .instr      (instr),
        .rd_reg_1   (dec_rd_reg_1),
        .rd_reg_2   (dec_rd_reg_2),
        .wr_reg     (dec_wr_reg),
        .sext_imm   (dec_sext_imm),
        .alu_op     (dec_alu_op),
        .use_imm    (dec_use_imm),
        .wr_en      (dec_wr_en),
        .halt_instr (dec_halt),
        .br_cnd     (dec_br_cnd)
    );

    // written back from the writeback stage
    reg_file reg_file_inst (
        .clk       (clk),
        .reset     (reset),
        .rd_reg_1  (dec_rd_reg_1),
        .rd_reg_2  (dec_rd_reg_2),
        .wr_en     (wb_en),
        .wr_reg    (wb_reg),
        .wr_data   (wb_data),
        .rd_data_1 (rf_data_1),
        .rd_data_2 (rf_data_2)
    );

    id_ex id_ex_inst (
        .clk           (clk),
        .reset         (reset),
        .valid         (instr_valid),
        .take_new_pc   (redirect),      // a taken branch squashes the next instruction
        .in_pc_inc     (pc_inc),
        .in_rd_data_1  (rf_data_1),
        .in_rd_data_2  (rf_data_2),
        .in_rd_reg_1   (dec_rd_reg_1),
        .in_rd_reg_2   (dec_rd_reg_2),
        .in_wr_reg     (dec_wr_reg),
        .in_sext_imm   (dec_sext_imm),
        .in_alu_op     (dec_alu_op),
        .in_use_imm    (dec_use_imm),
        .in_wr_en      (dec_wr_en),
        .in_br_cnd     (dec_br_cnd),
        .in_halt       (dec_halt),
        .out_pc_inc    (ex_pc_inc),
        .out_rd_data_1 (ex_rd_data_1),
        .out_rd_data_2 (ex_rd_data_2),
        .out_rd_reg_1  (ex_rd_reg_1),
        .out_rd_reg_2  (ex_rd_reg_2),
        .out_wr_reg    (ex_wr_reg),
        .out_sext_imm  (ex_sext_imm),
        .out_alu_op    (ex_alu_op),
        .out_use_imm   (ex_use_imm),
        .out_wr_en     (ex_wr_en),
        .out_br_cnd    (ex_br_cnd),
        .out_halt      (ex_halt)
    );

    alu_exec alu_exec_inst (
        .clk         (clk),
        .reset       (reset),
        .pc_inc      (ex_pc_inc),
        .rd_data_1   (ex_rd_data_1),
        .rd_data_2   (ex_rd_data_2),
        .rd_reg_1    (ex_rd_reg_1),
        .rd_reg_2    (ex_rd_reg_2),
        .wr_reg      (ex_wr_reg),
        .sext_imm    (ex_sext_imm),
        .alu_op      (ex_alu_op),
        .use_imm     (ex_use_imm),
        .wr_en       (ex_wr_en),
        .br_cnd      (ex_br_cnd),
        .halt_instr  (ex_halt),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .wb_en       (wb_en),
        .wb_reg      (wb_reg),
        .wb_data     (wb_data),
        .halt        (halt)
    );

endmodule

/* tests/pipe_core_tb.sv */
module pipe_core_tb;

    localparam int clk_period = 4;
    localparam int mem_words  = 256;

    logic        clk;
    logic        reset;
    logic        instr_valid;
    logic [15:0] pc;
    logic [15:0] instr;
    logic        redirect;
    logic [15:0] redirect_pc;
    logic        wb_en;
    logic [2:0]  wb_reg;
    logic [15:0] wb_data;
    logic        halt;

    logic [15:0] prog_mem [mem_words];
    logic [2:0]  exp_reg_q [$];
    logic [15:0] exp_data_q [$];
    int          prog_words;
    logic        trace_loaded;
    logic        fetch_started;   // first valid instruction driven
    logic        ex_live;         // an accepted instruction sits in execute
    logic [15:0] ex_pc;
    logic [15:0] ex_instr;

    pipe_core pipe_core_inst (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .pc          (pc),
        .instr       (instr),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .wb_en       (wb_en),
        .wb_reg      (wb_reg),
        .wb_data     (wb_data),
        .halt        (halt)
    );

    task automatic stop_with_error(input string reason);
        $display("%s", reason);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [15:0] actual,
                               input logic [15:0] expected);
        if (actual !== expected) begin
            stop_with_error($sformatf("Mismatch %s: got %h, expected %h", name, actual, expected));
        end
    endtask

    // a taken branch or jump goes to its pc plus 2 plus the sign-extended offset
    function automatic logic [15:0] branch_target(input logic [15:0] at_pc,
                                                  input logic [15:0] word);
        logic [15:0] offset;
        if (word[15:11] == 5'b10000) begin
            offset = {{5{word[10]}}, word[10:0]};   // j
        end else begin
            offset = {{8{word[7]}}, word[7:0]};
        end
        return at_pc + 16'd2 + offset;
    endfunction

    task automatic load_trace();
        int               fd;
        int               code;
        logic [7:0]       tag;
        logic [15:0]      field_1;
        logic [15:0]      field_2;
        logic [8*128-1:0] rest;
        bit               done;
        for (int i = 0; i < mem_words; i++) begin
            prog_mem[i] = {5'b00110, 3'b000, i[7:0]};   // unused opcode decodes as a nop
        end
        prog_words = 0;
        done = 1'b0;
        fd = $fopen("tests/pipe_trace.txt", "r");
        if (fd == 0) begin
            stop_with_error("cannot open the trace file tests/pipe_trace.txt");
        end else begin
            while (!done) begin
                code = $fscanf(fd, " %c", tag);
                if (code != 1) begin
                    done = 1'b1;
                end else if (tag == "#") begin
                    code = $fgets(rest, fd);   // rest of a comment line
                end else begin
                    code = $fscanf(fd, "%h %h", field_1, field_2);
                    if (code != 2) begin
                        stop_with_error("malformed line in the trace file");
                    end else if (tag == "P") begin
                        prog_mem[field_1[8:1]] = field_2;
                        prog_words++;
                    end else if (tag == "W") begin
                        exp_reg_q.push_back(field_1[2:0]);
                        exp_data_q.push_back(field_2);
                    end else begin
                        stop_with_error("unknown record type in the trace file");
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // fetch model that follows redirects and drops in random bubbles
    initial begin
        int          seed;
        logic        take;
        logic [15:0] target;
        logic [15:0] fetch_pc;
        seed = $urandom(32'hf23c);
        reset = 1'b1;
        instr_valid = 1'b0;
        pc = '0;
        instr = '0;
        fetch_pc = '0;
        fetch_started = 1'b0;
        ex_live = 1'b0;
        ex_pc = '0;
        ex_instr = '0;
        trace_loaded = 1'b0;
        load_trace();
        trace_loaded = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (3) @(posedge clk);   // outputs must stay quiet until the first fetch
        forever begin
            @(negedge clk);
            take = redirect;
            target = redirect_pc;
            @(posedge clk);
            #1;
            ex_live = instr_valid && (take !== 1'b1);   // squashed under a redirect
            ex_pc = pc;
            ex_instr = instr;
            if (take === 1'b1) begin
                fetch_pc = target;
            end else if (instr_valid) begin
                fetch_pc = fetch_pc + 16'd2;
            end
            pc = fetch_pc;
            instr = prog_mem[fetch_pc[8:1]];
            if (($urandom % 4) == 0) begin
                instr_valid = 1'b0;
            end else begin
                instr_valid = 1'b1;
                fetch_started = 1'b1;
            end
        end
    end

    // writeback monitor samples the outputs mid-cycle
    initial begin
        bit         halt_seen;
        logic [4:0] ex_op;
        halt_seen = 1'b0;
        wait (reset === 1'b0);
        while (!halt_seen) begin
            @(negedge clk);
            if (!fetch_started) begin
                check_value("wb_en", wb_en, 16'h0000);
                check_value("redirect", redirect, 16'h0000);
                check_value("halt", halt, 16'h0000);
            end
            if (redirect === 1'b1) begin
                ex_op = ex_instr[15:11];
                if (!ex_live || !(ex_op == 5'b01100 || ex_op == 5'b01101 || ex_op == 5'b10000)) begin
                    stop_with_error("a redirect came with no branch or jump in execute");
                end else begin
                    check_value("redirect_pc", redirect_pc, branch_target(ex_pc, ex_instr));
                end
            end
            if (wb_en === 1'b1) begin
                if (exp_reg_q.size() == 0) begin
                    stop_with_error("a writeback came after the last expected one");
                end else begin
                    check_value("wb_reg", wb_reg, exp_reg_q.pop_front());
                    check_value("wb_data", wb_data, exp_data_q.pop_front());
                end
            end
            halt_seen = (halt === 1'b1);
        end
        if (exp_reg_q.size() != 0) begin
            stop_with_error($sformatf("halt reached with %0d expected writebacks missing",
                                      exp_reg_q.size()));
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

    initial begin
        wait (trace_loaded === 1'b1);
        #((prog_words * 20 + 50) * clk_period);
        stop_with_error("timeout, the program never reached halt");
    end

endmodule

/* tests/pipe_trace.txt */
# P <address> <instruction>  program word, hex
# W <register> <data>        expected writeback in order, hex
P 0000 4105
W 1 0005
P 0002 423D
W 2 0002
P 0004 094C
W 3 0007
P 0006 1270
W 4 FFFB
P 0008 2C34
W 5 0001
P 000A 2998
W 6 0000
P 000C 1C7C
W 7 0003
P 000E 2438
W 6 FFFE
P 0010 40D0
W 0 FFEE
P 0012 28C4
W 1 0001
P 0014 6504
P 0016 6904
P 0018 F800
P 001A 4241
P 001C 430F
W 3 FFFD
P 001E 1368
W 2 0000
P 0020 6206
P 0022 47E1
P 0024 F800
P 0026 47E1
P 0028 8016
P 002A 4481
P 0040 87EE
P 0042 F800
P 0030 0C90
W 4 FFF6
P 0032 24F4
W 5 FFF5
P 0034 46BF
W 6 FFF4
P 0036 0000
P 0038 F800

/* filelist.f */
src/cpu_isa_pkg.sv
src/cpu_ctrl_pkg.sv
src/instr_decoder.sv
src/reg_file.sv
src/id_ex.sv
src/alu_exec.sv
src/pipe_core.sv
tests/pipe_core_tb.sv

/* Bender.yml */
package:
  name: pipe_core

sources:
  - src/cpu_isa_pkg.sv
  - src/cpu_ctrl_pkg.sv
  - src/instr_decoder.sv
  - src/reg_file.sv
  - src/id_ex.sv
  - src/alu_exec.sv
  - src/pipe_core.sv
  - target: test
    files:
      - tests/pipe_core_tb.sv
